// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen = 32;  // rv32 register and address width

    typedef logic [xlen-1:0] addr_t;  // instruction address
    typedef logic [xlen-1:0] word_t;  // register value or sign-extended immediate

    // control transfer class of a fetched instruction, set by decode
    typedef enum logic [1:0] {
        kind_none,  // falls through to pc+4
        kind_jal,   // pc relative jump, always taken
        kind_jalr,  // register indirect jump, always taken
        kind_cond   // conditional branch, predicted by the table
    } insn_kind_t;

endpackage

// ==== verilog/bp_pkg.sv ====
package bp_pkg;

    // 2-bit saturating counter, 0 and 1 predict not taken, 2 and 3 predict taken
    typedef logic [1:0] counter_t;

    localparam counter_t ctr_init = 2'd1;  // weakly not taken
    localparam counter_t ctr_max  = 2'd3;  // strongly taken
    localparam counter_t ctr_min  = 2'd0;  // strongly not taken

    localparam int default_index_bits = 10;  // 1024 counters, pc[11:2]
    localparam int default_fifo_depth = 8;   // in-flight conditional branches, power of two

endpackage

// ==== verilog/branch_if.sv ====
`timescale 1ns/1ns

interface branch_if;
    import rv_pkg::*;

    logic  valid;         // record present
    addr_t pc;            // pc of the conditional branch
    logic  pred_taken;    // direction predicted at fetch
    addr_t taken_target;  // pc+imm, used if the branch is actually taken

    modport src (
        output valid,
        output pc,
        output pred_taken,
        output taken_target
    );

    modport dst (
        input valid,
        input pc,
        input pred_taken,
        input taken_target
    );

endinterface

// ==== verilog/branch_history_table.sv ====
`timescale 1ns/1ns

module branch_history_table #(
    parameter int index_bits = bp_pkg::default_index_bits
) (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::addr_t    rd_pc,
    output bp_pkg::counter_t rd_ctr,
    input  logic             upd_en,
    input  rv_pkg::addr_t    upd_pc,
    input  logic             upd_taken
);
    import bp_pkg::*;

    localparam int entries = 2 ** index_bits;

    typedef logic [index_bits-1:0] index_t;

    counter_t ctr_q [entries];
    index_t   rd_idx;
    index_t   upd_idx;
    counter_t upd_old;

    // word aligned pcs, so bits 1:0 carry no information
    assign rd_idx  = rd_pc[index_bits+1:2];
    assign upd_idx = upd_pc[index_bits+1:2];

    assign rd_ctr  = ctr_q[rd_idx];  // old content, an update this cycle lands at the edge
    assign upd_old = ctr_q[upd_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                ctr_q[i] <= ctr_init;
            end
        end else if (upd_en) begin
            if (upd_taken) begin
                if (upd_old != ctr_max) begin
                    ctr_q[upd_idx] <= upd_old + 2'd1;  // count up toward taken
                end
            end else begin
                if (upd_old != ctr_min) begin
                    ctr_q[upd_idx] <= upd_old - 2'd1;  // count down toward not taken
                end
            end
        end
    end

endmodule

// ==== verilog/next_pc_unit.sv ====
`timescale 1ns/1ns

module next_pc_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue,
    input  rv_pkg::insn_kind_t kind,
    input  rv_pkg::addr_t      pc,
    input  rv_pkg::word_t      imm,
    input  rv_pkg::word_t      rs1_data,
    input  bp_pkg::counter_t   ctr,
    output logic               pred_valid,
    output logic               pred_taken,
    output rv_pkg::addr_t      pred_target,
    branch_if.src              issue_bus
);
    import rv_pkg::*;

    addr_t seq_pc;     // fall-through address
    addr_t br_target;  // pc relative target of jal and branches
    word_t jalr_sum;
    logic  cond_taken;
    logic  taken_d;
    addr_t target_d;

    assign seq_pc     = pc + 32'd4;
    assign br_target  = pc + imm;
    assign jalr_sum   = rs1_data + imm;
    assign cond_taken = ctr[1];  // upper bit set means counter is 2 or 3

    always_comb begin
        case (kind)
            kind_jal: begin
                taken_d  = 1'b1;
                target_d = br_target;
            end
            kind_jalr: begin
                taken_d  = 1'b1;
                target_d = {jalr_sum[31:1], 1'b0};  // jalr clears bit 0
            end
            kind_cond: begin
                taken_d  = cond_taken;
                target_d = cond_taken ? br_target : seq_pc;
            end
            default: begin
                taken_d  = 1'b0;
                target_d = seq_pc;
            end
        endcase
    end

    // strobes reset, payload follows the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            pred_valid      <= 1'b0;
            issue_bus.valid <= 1'b0;
        end else begin
            pred_valid      <= issue;
            issue_bus.valid <= issue && (kind == kind_cond);  // only conditionals wait for ex
        end
    end

    always_ff @(posedge clk) begin
        pred_taken             <= taken_d;
        pred_target            <= target_d;
        issue_bus.pc           <= pc;
        issue_bus.pred_taken   <= cond_taken;
        issue_bus.taken_target <= br_target;
    end

endmodule

// ==== verilog/inflight_branch_fifo.sv ====
`timescale 1ns/1ns

module inflight_branch_fifo #(
    parameter int fifo_depth = bp_pkg::default_fifo_depth
) (
    input  logic  clk,
    input  logic  rst,
    branch_if.dst push_bus,
    branch_if.src head_bus,
    input  logic  pop,
    output logic  overflow
);
    import rv_pkg::*;

    localparam int ptr_bits = $clog2(fifo_depth);

    typedef logic [ptr_bits:0] ptr_t;  // extra wrap bit tells full from empty

    addr_t pc_mem     [fifo_depth];
    logic  taken_mem  [fifo_depth];
    addr_t target_mem [fifo_depth];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    logic empty;
    logic full;
    logic do_push;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ptr_bits] != rd_ptr[ptr_bits]) &&
                   (wr_ptr[ptr_bits-1:0] == rd_ptr[ptr_bits-1:0]);

    // a slot freed by a pop in the same cycle can take the new record
    assign do_push = push_bus.valid && (!full || pop);

    assign head_bus.valid        = !empty;
    assign head_bus.pc           = pc_mem[rd_ptr[ptr_bits-1:0]];
    assign head_bus.pred_taken   = taken_mem[rd_ptr[ptr_bits-1:0]];
    assign head_bus.taken_target = target_mem[rd_ptr[ptr_bits-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push_bus.valid && !do_push) begin
                overflow <= 1'b1;  // sticky, record is lost
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr[ptr_bits-1:0]]     <= push_bus.pc;
            taken_mem[wr_ptr[ptr_bits-1:0]]  <= push_bus.pred_taken;
            target_mem[wr_ptr[ptr_bits-1:0]] <= push_bus.taken_target;
        end
    end

endmodule

// ==== verilog/branch_resolver.sv ====
`timescale 1ns/1ns

module branch_resolver (
    input  logic          clk,
    input  logic          rst,
    input  logic          resolve,
    input  logic          actual_taken,
    branch_if.dst         head_bus,
    output logic          pop,
    output logic          upd_en,
    output rv_pkg::addr_t upd_pc,
    output logic          upd_taken,
    output logic          resolved_valid,
    output logic          mispredict,
    output rv_pkg::addr_t redirect_pc
);
    import rv_pkg::*;

    logic  take;       // outcome matches a held prediction
    logic  wrong;
    addr_t correct_pc;

    // a strobe with nothing in flight is ignored
    assign take = resolve && head_bus.valid;
    assign pop  = take;

    // train at the same edge that raises resolved_valid
    assign upd_en    = take;
    assign upd_pc    = head_bus.pc;
    assign upd_taken = actual_taken;

    assign wrong      = (head_bus.pred_taken != actual_taken);
    assign correct_pc = actual_taken ? head_bus.taken_target : head_bus.pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            resolved_valid <= 1'b0;
            mispredict     <= 1'b0;
        end else begin
            resolved_valid <= take;
            mispredict     <= take && wrong;  // only meaningful with resolved_valid
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            redirect_pc <= correct_pc;  // held until the next resolution
        end
    end

endmodule

// ==== verilog/branch_unit_top.sv ====
`timescale 1ns/1ns

module branch_unit_top #(
    parameter int index_bits = bp_pkg::default_index_bits,
    parameter int fifo_depth = bp_pkg::default_fifo_depth
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue,
    input  rv_pkg::insn_kind_t kind,
    input  rv_pkg::addr_t      pc,
    input  rv_pkg::word_t      imm,
    input  rv_pkg::word_t      rs1_data,
    input  logic               resolve,
    input  logic               actual_taken,
    output logic               pred_valid,
    output logic               pred_taken,
    output rv_pkg::addr_t      pred_target,
    output logic               resolved_valid,
    output logic               mispredict,
    output rv_pkg::addr_t      redirect_pc,
    output logic               overflow
);
    import rv_pkg::*;
    import bp_pkg::*;

    counter_t ctr;      // counter for the fetch pc
    logic     pop;
    logic     upd_en;
    addr_t    upd_pc;
    logic     upd_taken;

    branch_if issue_bus ();  // next-pc unit to fifo
    branch_if head_bus ();   // fifo head to resolver

    next_pc_unit next_pc_unit_i (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .kind        (kind),
        .pc          (pc),
        .imm         (imm),
        .rs1_data    (rs1_data),
        .ctr         (ctr),
        .pred_valid  (pred_valid),
        .pred_taken  (pred_taken),
        .pred_target (pred_target),
        .issue_bus   (issue_bus)
    );

    branch_history_table #(
        .index_bits (index_bits)
    ) branch_history_table_i (
        .clk       (clk),
        .rst       (rst),
        .rd_pc     (pc),
        .rd_ctr    (ctr),
        .upd_en    (upd_en),
        .upd_pc    (upd_pc),
        .upd_taken (upd_taken)
    );

    inflight_branch_fifo #(
        .fifo_depth (fifo_depth)
    ) inflight_branch_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .push_bus (issue_bus),
        .head_bus (head_bus),
        .pop      (pop),
        .overflow (overflow)
    );

    branch_resolver branch_resolver_i (
        .clk            (clk),
        .rst            (rst),
        .resolve        (resolve),
        .actual_taken   (actual_taken),
        .head_bus       (head_bus),
        .pop            (pop),
        .upd_en         (upd_en),
        .upd_pc         (upd_pc),
        .upd_taken      (upd_taken),
        .resolved_valid (resolved_valid),
        .mispredict     (mispredict),
        .redirect_pc    (redirect_pc)
    );

endmodule

// ==== tb/clock_gen.sv ====
`timescale 1ns/1ns

module clock_gen #(
    parameter int period       = 40,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;  // released on an edge, sampled low at the next one
    end

endmodule

// ==== tb/tb_branch_unit.sv ====
`timescale 1ns/1ns

module tb_branch_unit;
    import rv_pkg::*;
    import bp_pkg::*;

    localparam int period     = 40;
    localparam int index_bits = default_index_bits;
    localparam int fifo_depth = default_fifo_depth;
    localparam int n_random   = 300;
    localparam int n_directed = 200;  // generous bound on the directed cycles
    localparam int num_ops    = n_random + n_directed;

    typedef struct packed {
        logic [31:0] pc;
        logic        pred;
        logic [31:0] tgt;
    } rec_t;

    logic clk, rst, issue, resolve, actual_taken;
    insn_kind_t kind;
    addr_t pc;
    word_t imm, rs1_data;
    logic pred_valid, pred_taken, resolved_valid, mispredict, overflow;
    addr_t pred_target, redirect_pc;

    logic [1:0] ref_ctr [2 ** index_bits];  // model of the counter table
    rec_t inflight_q [$];
    rec_t pend_rec;      // issued last cycle, pushed at the end of this one
    logic pend_valid = 1'b0;
    logic checking = 1'b0;
    int dut_res_count = 0;
    logic [31:0] seed = 32'h5c3d_4f50;

    // expected outputs for the current cycle and for the next one
    logic exp_pv = 0, exp_pt = 0, exp_rv = 0, exp_mp = 0, exp_ov = 0;
    logic nxt_pv = 0, nxt_pt = 0, nxt_rv = 0, nxt_mp = 0, nxt_ov = 0;
    logic [31:0] exp_ptgt = 0, exp_redir = 0, nxt_ptgt = 0, nxt_redir = 0;

    clock_gen #(.period(period), .reset_cycles(8)) clock_gen_i (.clk(clk), .rst(rst));

    branch_unit_top #(
        .index_bits (index_bits),
        .fifo_depth (fifo_depth)
    ) branch_unit_top_i (
        .clk(clk), .rst(rst), .issue(issue), .kind(kind), .pc(pc), .imm(imm),
        .rs1_data(rs1_data), .resolve(resolve), .actual_taken(actual_taken),
        .pred_valid(pred_valid), .pred_taken(pred_taken), .pred_target(pred_target),
        .resolved_valid(resolved_valid), .mispredict(mispredict),
        .redirect_pc(redirect_pc), .overflow(overflow)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // {taken, target} for one fetched instruction
    function automatic logic [32:0] predict_next(input insn_kind_t k, input logic [31:0] p,
                                                 input logic [31:0] im, input logic [31:0] r1,
                                                 input logic [1:0] c);
        logic [31:0] sum;
        sum = r1 + im;
        case (k)
            kind_jal:  return {1'b1, p + im};
            kind_jalr: return {1'b1, sum & 32'hffff_fffe};
            kind_cond: return (c >= 2'd2) ? {1'b1, p + im} : {1'b0, p + 32'd4};
            default:   return {1'b0, p + 32'd4};
        endcase
    endfunction

    // {mispredict, redirect} for the oldest record
    function automatic logic [32:0] resolve_next(input rec_t r, input logic act);
        return {r.pred != act, act ? r.tgt : r.pc + 32'd4};
    endfunction

    function automatic logic [1:0] train(input logic [1:0] c, input logic taken);
        if (taken && c < 2'd3) return c + 2'd1;
        if (!taken && c > 2'd0) return c - 2'd1;
        return c;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s actual 0x%h expected 0x%h", name, actual, expected);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one clock cycle of stimulus plus the model step for it
    task automatic do_cycle(input logic iss, input insn_kind_t k, input logic [31:0] p,
                            input logic [31:0] im, input logic [31:0] r1,
                            input logic res, input logic act);
        logic [32:0] pr;
        logic [32:0] rr;
        rec_t head;
        int idx;
        @(posedge clk);
        issue <= iss;
        kind <= k;
        pc <= p;
        imm <= im;
        rs1_data <= r1;
        resolve <= res;
        actual_taken <= act;
        checking = 1'b1;
        {exp_pv, exp_pt, exp_ptgt} = {nxt_pv, nxt_pt, nxt_ptgt};
        {exp_rv, exp_mp, exp_redir, exp_ov} = {nxt_rv, nxt_mp, nxt_redir, nxt_ov};
        pr = predict_next(k, p, im, r1, ref_ctr[p[index_bits+1:2]]);  // table as it is now
        {nxt_pv, nxt_pt, nxt_ptgt} = {iss, pr};
        nxt_rv = 1'b0;
        nxt_mp = 1'b0;
        if (res && inflight_q.size() > 0) begin
            head = inflight_q.pop_front();
            rr = resolve_next(head, act);
            {nxt_rv, nxt_mp, nxt_redir} = {1'b1, rr};
            idx = head.pc[index_bits+1:2];
            ref_ctr[idx] = train(ref_ctr[idx], act);
        end
        if (pend_valid) begin
            if (inflight_q.size() < fifo_depth) inflight_q.push_back(pend_rec);
            else nxt_ov = 1'b1;  // record lost
        end
        pend_valid = iss && (k == kind_cond);
        pend_rec = '{pc: p, pred: pr[32], tgt: p + im};
    endtask

    task automatic idle(input int n);
        repeat (n) do_cycle(1'b0, kind_none, 0, 0, 0, 1'b0, 1'b0);
    endtask

    task automatic cond_round(input logic [31:0] p, input logic [31:0] im, input logic act);
        do_cycle(1'b1, kind_cond, p, im, 0, 1'b0, 1'b0);
        idle(1);
        do_cycle(1'b0, kind_none, 0, 0, 0, 1'b1, act);  // record is at the head by now
    endtask

    task automatic drain();
        while (inflight_q.size() > 0 || pend_valid) begin
            do_cycle(1'b0, kind_none, 0, 0, 0, 1'b1, 1'b0);
        end
    endtask

    always @(negedge clk) begin
        if (checking) begin
            check_value("pred_valid", pred_valid, exp_pv);
            if (exp_pv) begin
                check_value("pred_taken", pred_taken, exp_pt);
                check_value("pred_target", pred_target, exp_ptgt);
            end
            check_value("resolved_valid", resolved_valid, exp_rv);
            check_value("mispredict", mispredict, exp_mp);
            if (exp_rv) check_value("redirect_pc", redirect_pc, exp_redir);
            check_value("overflow", overflow, exp_ov);
            if (resolved_valid === 1'b1) dut_res_count++;
        end
    end

    initial begin
        #((num_ops + 50) * period);
        $display("timeout, the tests did not finish in the expected number of cycles");
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        insn_kind_t k;
        logic [31:0] r;
        logic [31:0] p;
        logic [31:0] im;
        int busy;
        int res_before;
        issue = 1'b0;
        kind = kind_none;
        pc = '0;
        imm = '0;
        rs1_data = '0;
        resolve = 1'b0;
        actual_taken = 1'b0;
        for (int i = 0; i < 2 ** index_bits; i++) ref_ctr[i] = ctr_init;
        @(posedge clk);
        while (rst) @(posedge clk);

        cond_round(32'h0000_0100, 32'h40, 1'b0);  // fresh table predicts not taken
        do_cycle(1'b1, kind_none, 32'h300, 32'h40, 0, 1'b1, 1'b1);  // empty resolve too
        do_cycle(1'b1, kind_jal, 32'h304, 32'hffff_ff00, 0, 1'b0, 1'b0);
        do_cycle(1'b1, kind_jalr, 32'h308, 32'h15, 32'h1000_0002, 1'b1, 1'b0);
        idle(3);

        // A and B alias on pc[11:2]
        cond_round(32'h0000_0200, 32'h80, 1'b1);
        cond_round(32'h0000_1200, 32'h80, 1'b1);
        cond_round(32'h0000_0200, 32'h80, 1'b1);  // saturates at 3
        cond_round(32'h0000_1200, 32'h80, 1'b0);
        cond_round(32'h0000_0200, 32'h80, 1'b0);
        cond_round(32'h0000_1200, 32'h80, 1'b1);  // predicted not taken again
        cond_round(32'h0000_0200, 32'h80, 1'b0);
        cond_round(32'h0000_1200, 32'h80, 1'b0);
        cond_round(32'h0000_0200, 32'h80, 1'b0);  // stays at 0
        cond_round(32'h0000_1200, 32'h80, 1'b1);

        do_cycle(1'b1, kind_cond, 32'h400, 32'h20, 0, 1'b0, 1'b0);
        do_cycle(1'b1, kind_cond, 32'h404, 32'hffff_fff8, 0, 1'b0, 1'b0);
        do_cycle(1'b1, kind_cond, 32'h408, 32'h100, 0, 1'b1, 1'b1);
        do_cycle(1'b1, kind_cond, 32'h40c, 32'h10, 0, 1'b1, 1'b0);
        do_cycle(1'b0, kind_none, 0, 0, 0, 1'b1, 1'b1);
        do_cycle(1'b0, kind_none, 0, 0, 0, 1'b1, 1'b0);
        do_cycle(1'b0, kind_none, 0, 0, 0, 1'b1, 1'b1);  // FIFO is empty here
        idle(2);

        for (int n = 0; n < n_random; n++) begin
            seed = xorshift32(seed);
            r = seed;
            k = insn_kind_t'(r[1:0]);
            busy = inflight_q.size() + (pend_valid ? 1 : 0);
            if (k == kind_cond && busy >= fifo_depth) k = kind_none;  // keep within depth
            seed = xorshift32(seed);
            p = {16'h0, seed[15:2], 2'b00};
            seed = xorshift32(seed);
            im = {{20{seed[11]}}, seed[11:1], 1'b0};
            seed = xorshift32(seed);
            do_cycle(r[2] | r[3], k, p, im, seed, r[4] | r[5], r[6]);
        end
        drain();
        idle(2);
        @(negedge clk);
        check_value("overflow", overflow, 1'b0);

        res_before = dut_res_count;
        for (int n = 0; n <= fifo_depth; n++) begin
            do_cycle(1'b1, kind_cond, 32'h800 + 4 * n, 32'h40, 0, 1'b0, 1'b0);
        end
        idle(2);
        @(negedge clk);
        check_value("overflow", overflow, 1'b1);
        repeat (fifo_depth + 1) do_cycle(1'b0, kind_none, 0, 0, 0, 1'b1, 1'b1);
        idle(2);
        check_value("resolution count", dut_res_count - res_before, fifo_depth);

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/rv_pkg.sv
verilog/bp_pkg.sv
verilog/branch_if.sv
verilog/branch_history_table.sv
verilog/next_pc_unit.sv
verilog/inflight_branch_fifo.sv
verilog/branch_resolver.sv
verilog/branch_unit_top.sv
tb/clock_gen.sv
tb/tb_branch_unit.sv

// ==== Bender.yml ====
package:
  name: branch_unit

sources:
  - files:
      - verilog/rv_pkg.sv
      - verilog/bp_pkg.sv
      - verilog/branch_if.sv
      - verilog/branch_history_table.sv
      - verilog/next_pc_unit.sv
      - verilog/inflight_branch_fifo.sv
      - verilog/branch_resolver.sv
      - verilog/branch_unit_top.sv
  - target: test
    files:
      - tb/clock_gen.sv
      - tb/tb_branch_unit.sv
